// File: verilog/pixelPkg.sv
// pixel formats and colour constants
package pixelPkg;

    // game colour, red in the low bits
    typedef struct packed {
        logic [4:0] blue;
        logic [4:0] green;
        logic [4:0] red;
    } gbPixel_t;

    typedef struct packed {
        logic [5:0] blue;
        logic [5:0] green;
        logic [5:0] red;
    } rgb666_t;

    // RGB565 menu word, bit 5 carries no colour
    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic       spare;
        logic [4:0] blue;
    } osdWord_t;

    localparam osdWord_t osdKey = 16'hF81F; // magenta, see-through

    // LCD matrix on the 5-bit channel halves
    localparam int corrRedR = 216;
    localparam int corrRedG = 30;
    localparam int corrRedB = 25; // subtracted, clamps at zero
    localparam int corrGrnR = 39;
    localparam int corrGrnG = 137;
    localparam int corrGrnB = 24;
    localparam int corrBluR = 21;
    localparam int corrBluG = 24;
    localparam int corrBluB = 125;

    localparam int corrShift  = 7;  // lsb of the 6-bit result
    localparam int corrSatBit = 13; // overflow into this bit saturates

    typedef enum logic [1:0] {
        MIX_PASS,
        MIX_OSD,
        MIX_CRUSH
    } mixSel_t;

endpackage

// File: verilog/framePkg.sv
// frame buffer geometry
package framePkg;

    localparam int fbAddrWidth = 23;

    // start of the game frame and words per line
    localparam logic [fbAddrWidth-1:0] fbDefaultBase = 23'h10000;
    localparam int fbDefaultStride = 320;

endpackage

// File: verilog/pixelBus.sv
// pixel pipeline stage bus
`timescale 1ns/1ps

interface pixelBus;
    import pixelPkg::*;

    logic     valid;
    logic     hsync;
    logic     vsync;
    rgb666_t  pixel;
    osdWord_t osd;    // menu word travels with its pixel
    logic     drawOsd;

    modport src (
        output valid, hsync, vsync, pixel, osd, drawOsd
    );

    modport dst (
        input valid, hsync, vsync, pixel, osd, drawOsd
    );

endinterface

// File: verilog/pixelIngest.sv
// game pixel ingest and frame blend
`timescale 1ns/1ps

module pixelIngest (
    input  logic               hClk,
    input  logic               reset,
    input  logic               frameBlendEnable,
    input  logic               drawOsd,
    input  logic               pixelValid,
    input  logic               hsyncIn,
    input  logic               vsyncIn,
    input  pixelPkg::gbPixel_t pixelIn,
    input  logic [15:0]        previousPixel,
    input  pixelPkg::osdWord_t osdPixel,
    pixelBus.src               stageOut
);
    import pixelPkg::*;

    gbPixel_t prevPixel;
    rgb666_t  widePixel;

    // 25% toward last frame, or plain widening
    function automatic logic [5:0] ingestChannel(
        input logic [4:0] cur,
        input logic [4:0] prev,
        input logic       blend
    );
        logic [6:0] sum;
        sum = 7'(prev) + 7'(cur) * 7'd3;
        ingestChannel = blend ? sum[6:1] : {cur, 1'b0};
    endfunction

    assign prevPixel = previousPixel[14:0]; // top bit is not colour

    always_comb begin
        widePixel.red   = ingestChannel(pixelIn.red, prevPixel.red, frameBlendEnable);
        widePixel.green = ingestChannel(pixelIn.green, prevPixel.green, frameBlendEnable);
        widePixel.blue  = ingestChannel(pixelIn.blue, prevPixel.blue, frameBlendEnable);
    end

    always_ff @(posedge hClk) begin
        if (reset) begin
            stageOut.valid   <= 1'b0;
            stageOut.hsync   <= 1'b0;
            stageOut.vsync   <= 1'b0;
            stageOut.drawOsd <= 1'b0;
        end else begin
            stageOut.valid   <= pixelValid;
            stageOut.hsync   <= hsyncIn;
            stageOut.vsync   <= vsyncIn;
            stageOut.drawOsd <= drawOsd;
        end
    end

    always_ff @(posedge hClk) begin
        stageOut.pixel <= widePixel;
        stageOut.osd   <= osdPixel;
    end

    // no pixels are sent during vertical sync
    validOutsideVsync: assert property (
        @(posedge hClk) disable iff (reset) !(vsyncIn && pixelValid)
    );

endmodule

// File: verilog/colorCorrect.sv
// LCD colour correction stage
`timescale 1ns/1ps

module colorCorrect (
    input  logic hClk,
    input  logic reset,
    input  logic correctEnable,
    pixelBus.dst stageIn,
    pixelBus.src stageOut
);
    import pixelPkg::*;

    logic [4:0]  r5;
    logic [4:0]  g5;
    logic [4:0]  b5;
    logic [15:0] redPos;
    logic [15:0] redNeg;
    logic [15:0] redSum;
    logic [15:0] grnSum;
    logic [15:0] bluSum;
    rgb666_t     corrected;

    function automatic logic [5:0] satChannel(input logic [15:0] sum);
        satChannel = sum[corrSatBit] ? 6'h3F : sum[corrShift +: 6];
    endfunction

    // matrix works on the 5-bit halves
    assign r5 = stageIn.pixel.red[5:1];
    assign g5 = stageIn.pixel.green[5:1];
    assign b5 = stageIn.pixel.blue[5:1];

    assign redPos = 16'(corrRedR * r5 + corrRedG * g5);
    assign redNeg = 16'(corrRedB * b5);
    assign redSum = (redPos < redNeg) ? '0 : redPos - redNeg; // clamp at black
    assign grnSum = 16'(corrGrnR * r5 + corrGrnG * g5 + corrGrnB * b5);
    assign bluSum = 16'(corrBluR * r5 + corrBluG * g5 + corrBluB * b5);

    always_comb begin
        corrected.red   = satChannel(redSum);
        corrected.green = satChannel(grnSum);
        corrected.blue  = satChannel(bluSum);
    end

    always_ff @(posedge hClk) begin
        if (reset) begin
            stageOut.valid   <= 1'b0;
            stageOut.hsync   <= 1'b0;
            stageOut.vsync   <= 1'b0;
            stageOut.drawOsd <= 1'b0;
        end else begin
            stageOut.valid   <= stageIn.valid;
            stageOut.hsync   <= stageIn.hsync;
            stageOut.vsync   <= stageIn.vsync;
            stageOut.drawOsd <= stageIn.drawOsd;
        end
    end

    always_ff @(posedge hClk) begin
        stageOut.pixel <= correctEnable ? corrected : stageIn.pixel;
        stageOut.osd   <= stageIn.osd;
    end

    // one-cycle stage, valid never stretched or dropped
    validOneCycle: assert property (
        @(posedge hClk) !reset && !$past(reset) |-> stageOut.valid == $past(stageIn.valid)
    );

endmodule

// File: verilog/osdMix.sv
// menu overlay mix
`timescale 1ns/1ps

module osdMix (
    input  logic              hClk,
    input  logic              reset,
    pixelBus.dst              stageIn,
    output logic              lcdValid,
    output logic              lcdHsync,
    output logic              lcdVsync,
    output pixelPkg::rgb666_t lcdPixel
);
    import pixelPkg::*;

    mixSel_t mixSel;
    rgb666_t osdColor;
    rgb666_t crushColor;
    rgb666_t mixPixel;

    always_comb begin
        if (stageIn.drawOsd && stageIn.osd == osdKey) begin
            mixSel = MIX_CRUSH; // key darkens the game behind the menu
        end else if (stageIn.drawOsd) begin
            mixSel = MIX_OSD;
        end else begin
            mixSel = MIX_PASS;
        end
    end

    // 565 to 666, lsb repeated
    always_comb begin
        osdColor.red    = {stageIn.osd.red, stageIn.osd.red[0]};
        osdColor.green  = {stageIn.osd.green, stageIn.osd.green[0]};
        osdColor.blue   = {stageIn.osd.blue, stageIn.osd.blue[0]};
        crushColor.red   = {2'd0, stageIn.pixel.red[5:2]};
        crushColor.green = {2'd0, stageIn.pixel.green[5:2]};
        crushColor.blue  = {2'd0, stageIn.pixel.blue[5:2]};
    end

    always_comb begin
        case (mixSel)
            MIX_OSD:   mixPixel = osdColor;
            MIX_CRUSH: mixPixel = crushColor;
            default:   mixPixel = stageIn.pixel;
        endcase
    end

    always_ff @(posedge hClk) begin
        if (reset) begin
            lcdValid <= 1'b0;
            lcdHsync <= 1'b0;
            lcdVsync <= 1'b0;
        end else begin
            lcdValid <= stageIn.valid;
            lcdHsync <= stageIn.hsync;
            lcdVsync <= stageIn.vsync;
        end
    end

    always_ff @(posedge hClk) begin
        lcdPixel <= mixPixel;
    end

    // menu latch and word must be known on every real pixel
    mixSelKnown: assert property (
        @(posedge hClk) disable iff (reset) stageIn.valid |-> !$isunknown(mixSel)
    );

endmodule

// File: verilog/fbWriter.sv
// frame buffer writer
`timescale 1ns/1ps

module fbWriter #(
    parameter logic [framePkg::fbAddrWidth-1:0] fbBase = framePkg::fbDefaultBase,
    parameter int lineStride = framePkg::fbDefaultStride
) (
    input  logic                             hClk,
    input  logic                             reset,
    input  logic                             btnMenu,
    input  logic                             pixelValid,
    input  logic                             hsyncIn,
    input  logic                             vsyncIn,
    input  logic [14:0]                      pixelIn,
    output logic                             fbWrite,
    output logic                             fbNewLine,
    output logic [framePkg::fbAddrWidth-1:0] fbAddress,
    output logic [15:0]                      fbData,
    output logic                             drawOsd
);
    import framePkg::*;

    localparam logic [fbAddrWidth-1:0] strideStep = fbAddrWidth'(lineStride);

    logic hsyncPrev;
    logic vsyncPrev;
    logic vsyncRise;

    assign fbWrite   = pixelValid;
    assign fbData    = {1'b0, pixelIn};
    assign fbNewLine = ~hsyncIn & hsyncPrev; // hsync falling edge
    assign vsyncRise = vsyncIn & ~vsyncPrev;

    always_ff @(posedge hClk) begin
        if (reset) begin
            hsyncPrev <= 1'b0;
            vsyncPrev <= 1'b0;
            fbAddress <= fbBase;
            drawOsd   <= 1'b0;
        end else begin
            hsyncPrev <= hsyncIn;
            vsyncPrev <= vsyncIn;
            if (vsyncRise) begin
                fbAddress <= fbBase;
                drawOsd   <= ~btnMenu; // button is active low
            end else if (fbNewLine && !vsyncIn) begin
                fbAddress <= fbAddress + strideStep;
            end
        end
    end

    newLineSingle: assert property (
        @(posedge hClk) disable iff (reset) fbNewLine |=> !fbNewLine
    );

endmodule

// File: verilog/vidPipeTop.sv
// video pixel path top
`timescale 1ns/1ps

module vidPipeTop #(
    parameter logic [framePkg::fbAddrWidth-1:0] fbBase = framePkg::fbDefaultBase,
    parameter int lineStride = framePkg::fbDefaultStride
) (
    input  logic                             hClk,
    input  logic                             reset,
    input  logic                             btnMenu,
    input  logic                             frameBlendEnable,
    input  logic                             correctEnable,
    input  logic                             pixelValid,
    input  logic                             hsyncIn,
    input  logic                             vsyncIn,
    input  pixelPkg::gbPixel_t               pixelIn,
    input  logic [15:0]                      previousPixel,
    input  pixelPkg::osdWord_t               osdPixel,
    output logic                             lcdValid,
    output logic                             lcdHsync,
    output logic                             lcdVsync,
    output pixelPkg::rgb666_t                lcdPixel,
    output logic                             fbWrite,
    output logic                             fbNewLine,
    output logic [framePkg::fbAddrWidth-1:0] fbAddress,
    output logic [15:0]                      fbData
);

    logic drawOsd; // latched once per frame

    pixelBus stageA ();
    pixelBus stageB ();

    pixelIngest uIngest (
        .hClk             (hClk),
        .reset            (reset),
        .frameBlendEnable (frameBlendEnable),
        .drawOsd          (drawOsd),
        .pixelValid       (pixelValid),
        .hsyncIn          (hsyncIn),
        .vsyncIn          (vsyncIn),
        .pixelIn          (pixelIn),
        .previousPixel    (previousPixel),
        .osdPixel         (osdPixel),
        .stageOut         (stageA)
    );

    colorCorrect uCorrect (
        .hClk          (hClk),
        .reset         (reset),
        .correctEnable (correctEnable),
        .stageIn       (stageA),
        .stageOut      (stageB)
    );

    osdMix uMix (
        .hClk     (hClk),
        .reset    (reset),
        .stageIn  (stageB),
        .lcdValid (lcdValid),
        .lcdHsync (lcdHsync),
        .lcdVsync (lcdVsync),
        .lcdPixel (lcdPixel)
    );

    // game frame store runs beside the pipeline
    fbWriter #(
        .fbBase     (fbBase),
        .lineStride (lineStride)
    ) uFbWriter (
        .hClk       (hClk),
        .reset      (reset),
        .btnMenu    (btnMenu),
        .pixelValid (pixelValid),
        .hsyncIn    (hsyncIn),
        .vsyncIn    (vsyncIn),
        .pixelIn    (pixelIn),
        .fbWrite    (fbWrite),
        .fbNewLine  (fbNewLine),
        .fbAddress  (fbAddress),
        .fbData     (fbData),
        .drawOsd    (drawOsd)
    );

endmodule

// File: sim/tbModel.svh
// pixel path reference model
`ifndef tbModelSvh
`define tbModelSvh

// 25% toward the previous frame or plain widening
function automatic logic [5:0] blendChannel(input logic [4:0] cur, input logic [4:0] prev,
                                            input logic blend);
    int sum;
    sum = int'(prev) + 3 * int'(cur);
    if (blend)
        return 6'(sum / 2);
    return 6'(int'(cur) * 2);
endfunction

function automatic logic [17:0] widenGamePixel(input logic [14:0] pix, input logic [15:0] prev,
                                               input logic blend);
    logic [5:0] red;
    logic [5:0] grn;
    logic [5:0] blu;
    red = blendChannel(pix[4:0], prev[4:0], blend);
    grn = blendChannel(pix[9:5], prev[9:5], blend);
    blu = blendChannel(pix[14:10], prev[14:10], blend);
    return {blu, grn, red};
endfunction

function automatic logic [5:0] saturateSum(input int sum);
    if (sum[13])
        return 6'd63;
    return 6'(sum >> 7); // bits 12 to 7
endfunction

function automatic logic [17:0] applyMatrix(input logic [17:0] px);
    int r;
    int g;
    int b;
    int red;
    int grn;
    int blu;
    r = int'(px[5:1]);
    g = int'(px[11:7]);
    b = int'(px[17:13]);
    red = 216 * r + 30 * g - 25 * b;
    if (red < 0)
        red = 0;
    grn = 39 * r + 137 * g + 24 * b;
    blu = 21 * r + 24 * g + 125 * b;
    return {saturateSum(blu), saturateSum(grn), saturateSum(red)};
endfunction

function automatic logic [17:0] widenOsdWord(input logic [15:0] word);
    logic [4:0] r5;
    logic [4:0] g5;
    logic [4:0] b5;
    r5 = word[15:11];
    g5 = word[10:6];
    b5 = word[4:0];
    return {b5, b5[0], g5, g5[0], r5, r5[0]};
endfunction

// expected lcd colour for one input pixel
function automatic logic [17:0] expectedPixel(input logic [14:0] pix, input logic [15:0] prev,
                                              input logic [15:0] osd, input logic blend,
                                              input logic correct, input logic drawOsd);
    logic [17:0] px;
    px = widenGamePixel(pix, prev, blend);
    if (correct)
        px = applyMatrix(px);
    if (!drawOsd)
        return px;
    if (osd == 16'hF81F)
        return {2'b00, px[17:14], 2'b00, px[11:8], 2'b00, px[5:2]}; // darkened
    return widenOsdWord(osd);
endfunction

function automatic logic [fbAddrWidth-1:0] nextFrameAddress(
    input logic [fbAddrWidth-1:0] addr,
    input logic                   newLine,
    input logic                   vsyncRise,
    input logic                   vsync
);
    if (vsyncRise)
        return fbDefaultBase;
    if (newLine && !vsync)
        return addr + fbAddrWidth'(fbDefaultStride);
    return addr;
endfunction

`endif

// File: sim/tbVidPipe.sv
// video pixel path testbench
`timescale 1ns/1ps

module tbVidPipe;
    import pixelPkg::*;
    import framePkg::*;

    `include "tbModel.svh"

    typedef struct packed {
        logic        valid;
        logic        hsync;
        logic        vsync;
        logic [17:0] pixel;
    } expectTuple_t;

    localparam int frameCount    = 10;
    localparam int linesPerFrame = 5;
    localparam int drainLimit    = 16; // cycles to wait for pending pixels

    logic                   hClk = 1'b0;
    logic                   reset;
    logic                   btnMenu;
    logic                   frameBlendEnable;
    logic                   correctEnable;
    logic                   pixelValid;
    logic                   hsyncIn;
    logic                   vsyncIn;
    logic [14:0]            pixelIn;
    logic [15:0]            previousPixel;
    logic [15:0]            osdPixel;
    logic                   lcdValid;
    logic                   lcdHsync;
    logic                   lcdVsync;
    logic [17:0]            lcdPixel;
    logic                   fbWrite;
    logic                   fbNewLine;
    logic [fbAddrWidth-1:0] fbAddress;
    logic [15:0]            fbData;

    logic [31:0]            lfsrState = 32'hebc017d6;
    expectTuple_t           expectQueue[$];
    logic                   btnState;
    logic                   blendState;
    logic                   correctState;
    logic                   lastHsync;
    logic                   lastVsync;
    logic                   lastBtn;
    logic                   modelHsyncPrev;
    logic                   modelVsyncPrev;
    logic                   modelDrawOsd;
    logic [fbAddrWidth-1:0] modelAddress;
    int                     pendingValid;
    int                     sentCount;
    int                     seenCount;

    vidPipeTop u_dut (
        .hClk             (hClk),
        .reset            (reset),
        .btnMenu          (btnMenu),
        .frameBlendEnable (frameBlendEnable),
        .correctEnable    (correctEnable),
        .pixelValid       (pixelValid),
        .hsyncIn          (hsyncIn),
        .vsyncIn          (vsyncIn),
        .pixelIn          (pixelIn),
        .previousPixel    (previousPixel),
        .osdPixel         (osdPixel),
        .lcdValid         (lcdValid),
        .lcdHsync         (lcdHsync),
        .lcdVsync         (lcdVsync),
        .lcdPixel         (lcdPixel),
        .fbWrite          (fbWrite),
        .fbNewLine        (fbNewLine),
        .fbAddress        (fbAddress),
        .fbData           (fbData)
    );

    always #50 hClk = ~hClk;

    // galois lfsr stepped once per bit
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsrState[0]};
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h80200003 : lfsrState >> 1;
        end
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error: %s is %h, expected %h", name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // lcd side pops the entry sent 3 cycles ago
    task automatic checkOutput();
        expectTuple_t entry;
        if (lcdValid) begin
            checkValue("scoreboard depth", 32'(expectQueue.size()), 32'd4);
            seenCount++;
        end
        if (expectQueue.size() > 3) begin
            entry = expectQueue.pop_front();
            checkValue("lcdValid", 32'(lcdValid), 32'(entry.valid));
            checkValue("lcdHsync", 32'(lcdHsync), 32'(entry.hsync));
            checkValue("lcdVsync", 32'(lcdVsync), 32'(entry.vsync));
            if (entry.valid) begin
                checkValue("lcdPixel", 32'(lcdPixel), 32'(entry.pixel));
                pendingValid--;
            end
        end
    endtask

    task automatic driveCycle(input logic valid, input logic hsync, input logic vsync);
        logic [14:0]  pix;
        logic [15:0]  prev;
        logic [15:0]  osd;
        logic         newLine;
        logic         rise;
        expectTuple_t entry;
        @(posedge hClk);
        pix  = 15'(randomBits(15));
        prev = 16'(randomBits(16));
        if (randomBits(2) == 32'd0)
            osd = osdKey;
        else
            osd = 16'(randomBits(16));
        pixelValid       <= valid;
        hsyncIn          <= hsync;
        vsyncIn          <= vsync;
        pixelIn          <= pix;
        previousPixel    <= prev;
        osdPixel         <= osd;
        btnMenu          <= btnState;
        frameBlendEnable <= blendState;
        correctEnable    <= correctState;
        // frame writer state after this edge uses last cycle's inputs
        newLine = ~lastHsync & modelHsyncPrev;
        rise    = lastVsync & ~modelVsyncPrev;
        modelAddress = nextFrameAddress(modelAddress, newLine, rise, lastVsync);
        if (rise)
            modelDrawOsd = ~lastBtn;
        modelHsyncPrev = lastHsync;
        modelVsyncPrev = lastVsync;
        entry.valid = valid;
        entry.hsync = hsync;
        entry.vsync = vsync;
        entry.pixel = expectedPixel(pix, prev, osd, blendState, correctState, modelDrawOsd);
        expectQueue.push_back(entry);
        if (valid) begin
            pendingValid++;
            sentCount++;
        end
        lastHsync = hsync;
        lastVsync = vsync;
        lastBtn   = btnState;
        @(negedge hClk);
        checkValue("fbWrite", 32'(fbWrite), 32'(valid));
        checkValue("fbData", 32'(fbData), 32'({1'b0, pix}));
        checkValue("fbNewLine", 32'(fbNewLine), 32'(~hsync & modelHsyncPrev));
        checkValue("fbAddress", 32'(fbAddress), 32'(modelAddress));
        checkOutput();
    endtask

    task automatic chooseFrameModes(input int frame);
        btnState     = (frame < 2) ? 1'b1 : (frame < 4) ? 1'b0 : 1'(randomBits(1));
        correctState = (frame < 4) ? 1'(frame % 2) : 1'(randomBits(1));
        blendState   = 1'(randomBits(1));
    endtask

    initial begin
        int pixels;
        int drainCycles;
        reset            = 1'b1;
        btnMenu          = 1'b1; // menu released
        frameBlendEnable = 1'b0;
        correctEnable    = 1'b0;
        pixelValid       = 1'b0;
        hsyncIn          = 1'b0;
        vsyncIn          = 1'b0;
        pixelIn          = '0;
        previousPixel    = '0;
        osdPixel         = '0;
        btnState = 1'b1;
        blendState = 1'b0;
        correctState = 1'b0;
        lastHsync = 1'b0;
        lastVsync = 1'b0;
        lastBtn = 1'b1;
        modelHsyncPrev = 1'b0;
        modelVsyncPrev = 1'b0;
        modelDrawOsd = 1'b0;
        modelAddress = fbDefaultBase;
        pendingValid = 0;
        sentCount = 0;
        seenCount = 0;

        repeat (3) @(posedge hClk);
        reset <= 1'b0;
        @(negedge hClk);
        checkValue("lcdValid", 32'(lcdValid), 32'd0);
        checkValue("lcdHsync", 32'(lcdHsync), 32'd0);
        checkValue("lcdVsync", 32'(lcdVsync), 32'd0);
        checkValue("fbNewLine", 32'(fbNewLine), 32'd0);
        checkValue("fbAddress", 32'(fbAddress), 32'(fbDefaultBase));

        for (int frame = 0; frame < frameCount; frame++) begin
            chooseFrameModes(frame);
            driveCycle(1'b0, 1'b0, 1'b1);
            driveCycle(1'b0, 1'b1, 1'b1); // hsync inside vsync gives no line step
            driveCycle(1'b0, 1'b1, 1'b1);
            driveCycle(1'b0, 1'b0, 1'b1);
            driveCycle(1'b0, 1'b0, 1'b0);
            for (int line = 0; line < linesPerFrame; line++) begin
                pixels = 10 + int'(randomBits(2));
                repeat (pixels) driveCycle(1'b1, 1'b0, 1'b0);
                driveCycle(1'b0, 1'b0, 1'b0);
                driveCycle(1'b0, 1'b1, 1'b0);
                driveCycle(1'b0, 1'b1, 1'b0);
                driveCycle(1'b0, 1'b0, 1'b0);
            end
            driveCycle(1'b0, 1'b0, 1'b0);
        end

        drainCycles = 0;
        while (pendingValid > 0) begin
            if (drainCycles >= drainLimit) begin
                $display("timeout: pixels sent but never seen at the lcd output");
                $display("STATUS: FAIL");
                $fatal(1, "drain timeout");
            end
            driveCycle(1'b0, 1'b0, 1'b0);
            drainCycles++;
        end
        checkValue("pixel count", 32'(seenCount), 32'(sentCount));
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: src.f
+incdir+sim
verilog/pixelPkg.sv
verilog/framePkg.sv
verilog/pixelBus.sv
verilog/pixelIngest.sv
verilog/colorCorrect.sv
verilog/osdMix.sv
verilog/fbWriter.sv
verilog/vidPipeTop.sv
sim/tbVidPipe.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbVidPipe
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "STATUS: FAIL" >> $(LOG)
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
